// File: Bender.yml
package:
  name: rvcore

sources:
  - hdl/rvPkg.sv
  - hdl/rvDecoder.sv
  - hdl/rvAlu.sv
  - hdl/rvRegFile.sv
  - hdl/rvSeqCtrl.sv
  - hdl/rvCore.sv
  - target: test
    files:
      - test/rvCore_checker.sv
      - test/rvCoreTb.sv

// File: hdl/rvAlu.sv
module rvAlu (
   input  rvPkg::aluOpE           aluOp,
   input  logic [rvPkg::Xlen-1:0] opA,
   input  logic [rvPkg::Xlen-1:0] opB,
   input  logic [rvPkg::Xlen-1:0] imm,
   input  logic                   useImm,
   output logic [rvPkg::Xlen-1:0] aluResult
);

   localparam int ShamtW = $clog2(rvPkg::Xlen);

   logic [rvPkg::Xlen-1:0] opSel;
   logic [ShamtW-1:0]      shamt;

   assign opSel = useImm ? imm : opB;
   assign shamt = opSel[ShamtW-1:0];   // only low bits shift

   always_comb begin
      case (aluOp)
         rvPkg::aluAdd: aluResult = opA + opSel;
         rvPkg::aluSub: aluResult = opA - opSel;
         rvPkg::aluXor: aluResult = opA ^ opSel;
         rvPkg::aluOr:  aluResult = opA | opSel;
         rvPkg::aluAnd: aluResult = opA & opSel;
         rvPkg::aluSll: aluResult = opA << shamt;
         rvPkg::aluSrl: aluResult = opA >> shamt;
         rvPkg::aluSra: aluResult = $signed(opA) >>> shamt;
         default:       aluResult = '0;
      endcase
   end

endmodule

// File: hdl/rvCore.sv
module rvCore #(
   parameter int unsigned AddrW   = 32,
   parameter int unsigned PcStart = 0
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   memVld,
   input  logic [rvPkg::Xlen-1:0] memRData,
   input  logic                   loadEn,
   output logic                   memRdy,
   output logic [AddrW-1:0]       memAddr,
   output logic                   memWEn,
   output logic [rvPkg::Xlen-1:0] memWData,
   output logic                   halt
);

   rvPkg::aluOpE              aluOp;
   logic [rvPkg::Xlen-1:0]    instr;
   logic [rvPkg::Xlen-1:0]    imm;
   logic [rvPkg::Xlen-1:0]    aluResult;
   logic [rvPkg::Xlen-1:0]    rs1Data;
   logic [rvPkg::Xlen-1:0]    rs2Data;
   logic [rvPkg::Xlen-1:0]    regWData;
   logic [rvPkg::RegIdxW-1:0] rs1;
   logic [rvPkg::RegIdxW-1:0] rs2;
   logic [rvPkg::RegIdxW-1:0] rd;
   logic [rvPkg::RegIdxW-1:0] regWAddr;
   logic                      regWEn;
   logic                      useImm;
   logic                      isAlu;
   logic                      isLui;
   logic                      isLoad;
   logic                      isStore;
   logic                      isHalt;
   logic                      isInvalid;

   rvSeqCtrl #(
      .AddrW   (AddrW),
      .PcStart (PcStart)
   ) i_rvSeqCtrl (
      .clk       (clk),
      .rstn      (rstn),
      .memVld    (memVld),
      .memRData  (memRData),
      .loadEn    (loadEn),
      .isAlu     (isAlu),
      .isLui     (isLui),
      .isLoad    (isLoad),
      .isStore   (isStore),
      .isHalt    (isHalt),
      .isInvalid (isInvalid),
      .imm       (imm),
      .rd        (rd),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),
      .instr     (instr),
      .memRdy    (memRdy),
      .memAddr   (memAddr),
      .memWEn    (memWEn),
      .memWData  (memWData),
      .halt      (halt),
      .regWEn    (regWEn),
      .regWAddr  (regWAddr),
      .regWData  (regWData)
   );

   rvDecoder i_rvDecoder (
      .instr     (instr),
      .aluOp     (aluOp),
      .rs1       (rs1),
      .rs2       (rs2),
      .rd        (rd),
      .imm       (imm),
      .useImm    (useImm),
      .isAlu     (isAlu),
      .isLui     (isLui),
      .isLoad    (isLoad),
      .isStore   (isStore),
      .isHalt    (isHalt),
      .isInvalid (isInvalid)
   );

   rvAlu i_rvAlu (
      .aluOp     (aluOp),
      .opA       (rs1Data),
      .opB       (rs2Data),
      .imm       (imm),
      .useImm    (useImm),
      .aluResult (aluResult)
   );

   rvRegFile i_rvRegFile (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (rs1),
      .rs2     (rs2),
      .wEn     (regWEn),
      .wAddr   (regWAddr),
      .wData   (regWData),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data)
   );

endmodule

// File: hdl/rvDecoder.sv
module rvDecoder (
   input  logic [rvPkg::Xlen-1:0]    instr,
   output rvPkg::aluOpE              aluOp,
   output logic [rvPkg::RegIdxW-1:0] rs1,
   output logic [rvPkg::RegIdxW-1:0] rs2,
   output logic [rvPkg::RegIdxW-1:0] rd,
   output logic [rvPkg::Xlen-1:0]    imm,
   output logic                      useImm,
   output logic                      isAlu,
   output logic                      isLui,
   output logic                      isLoad,
   output logic                      isStore,
   output logic                      isHalt,
   output logic                      isInvalid
);

   rvPkg::opcodeE                opcode;
   logic [rvPkg::Funct3W-1:0]    funct3;
   logic [rvPkg::Funct7W-1:0]    funct7;
   logic [rvPkg::Xlen-1:0]       immI;
   logic [rvPkg::Xlen-1:0]       immS;
   logic [rvPkg::Xlen-1:0]       immU;
   logic [rvPkg::Xlen-1:0]       shamt;

   assign opcode = rvPkg::opcodeE'(instr[rvPkg::OpcodeW-1:0]);
   assign funct3 = instr[rvPkg::Funct3Lsb +: rvPkg::Funct3W];
   assign funct7 = instr[rvPkg::Funct7Lsb +: rvPkg::Funct7W];
   assign rs1    = instr[rvPkg::Rs1Lsb +: rvPkg::RegIdxW];
   assign rs2    = instr[rvPkg::Rs2Lsb +: rvPkg::RegIdxW];
   assign rd     = instr[rvPkg::RdLsb +: rvPkg::RegIdxW];

   assign immI  = {{(rvPkg::Xlen-12){instr[31]}}, instr[31:20]};
   assign immS  = {{(rvPkg::Xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign immU  = {instr[31:12], 12'b0};                 // already shifted
   assign shamt = {{(rvPkg::Xlen-5){1'b0}}, instr[24:20]};

   assign useImm = (opcode != rvPkg::opReg);

   always_comb begin
      aluOp     = rvPkg::aluAdd;  // load/store address add
      imm       = immI;
      isAlu     = 1'b0;
      isLui     = 1'b0;
      isLoad    = 1'b0;
      isStore   = 1'b0;
      isHalt    = 1'b0;
      isInvalid = 1'b0;
      case (opcode)
         rvPkg::opImm: begin
            isAlu = 1'b1;
            case (funct3)
               3'b000: aluOp = rvPkg::aluAdd;
               3'b100: aluOp = rvPkg::aluXor;
               3'b110: aluOp = rvPkg::aluOr;
               3'b111: aluOp = rvPkg::aluAnd;
               3'b001: begin
                  aluOp     = rvPkg::aluSll;
                  imm       = shamt;
                  isInvalid = (funct7 != '0);
               end
               3'b101: begin
                  aluOp     = (funct7 == rvPkg::Funct7Alt) ? rvPkg::aluSra : rvPkg::aluSrl;
                  imm       = shamt;
                  isInvalid = (funct7 != '0) && (funct7 != rvPkg::Funct7Alt);
               end
               default: isInvalid = 1'b1;  // slti, sltiu
            endcase
         end
         rvPkg::opReg: begin
            isAlu = 1'b1;
            case ({funct7, funct3})
               {7'b0, 3'b000}:           aluOp = rvPkg::aluAdd;
               {rvPkg::Funct7Alt, 3'b000}: aluOp = rvPkg::aluSub;
               {7'b0, 3'b100}:           aluOp = rvPkg::aluXor;
               {7'b0, 3'b110}:           aluOp = rvPkg::aluOr;
               {7'b0, 3'b111}:           aluOp = rvPkg::aluAnd;
               {7'b0, 3'b001}:           aluOp = rvPkg::aluSll;
               default:                  isInvalid = 1'b1;
            endcase
         end
         rvPkg::opLui: begin
            isLui = 1'b1;
            imm   = immU;
         end
         rvPkg::opLoad: begin
            isLoad    = (funct3 == rvPkg::Funct3Lw);
            isInvalid = (funct3 != rvPkg::Funct3Lw);
         end
         rvPkg::opStore: begin
            imm       = immS;
            isStore   = (funct3 == rvPkg::Funct3Lw);
            isInvalid = (funct3 != rvPkg::Funct3Lw);
         end
         rvPkg::opHalt: isHalt = 1'b1;
         default:       isInvalid = 1'b1;
      endcase
      // a bad word never carries a class flag
      if (isInvalid) begin
         isAlu = 1'b0;
      end
   end

endmodule

// File: hdl/rvPkg.sv
package rvPkg;

   // datapath widths
   localparam int Xlen    = 32;
   localparam int RegIdxW = 5;

   // instruction field widths
   localparam int OpcodeW = 7;
   localparam int Funct3W = 3;
   localparam int Funct7W = 7;

   // lsb of each field in the instruction word
   localparam int RdLsb     = 7;
   localparam int Funct3Lsb = 12;
   localparam int Rs1Lsb    = 15;
   localparam int Rs2Lsb    = 20;
   localparam int Funct7Lsb = 25;

   // major opcodes
   typedef enum logic [OpcodeW-1:0] {
      opLoad  = 7'b0000011,
      opImm   = 7'b0010011,
      opStore = 7'b0100011,
      opReg   = 7'b0110011,
      opLui   = 7'b0110111,
      opHalt  = 7'b1111111
   } opcodeE;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluOr,
      aluAnd,
      aluSll,
      aluSrl,
      aluSra
   } aluOpE;

   // funct7 of SUB and SRAI
   localparam logic [Funct7W-1:0] Funct7Alt = 7'b0100000;

   // word access, LW and SW
   localparam logic [Funct3W-1:0] Funct3Lw = 3'b010;

endpackage

// File: hdl/rvRegFile.sv
module rvRegFile (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic [rvPkg::RegIdxW-1:0] rs1,
   input  logic [rvPkg::RegIdxW-1:0] rs2,
   input  logic                      wEn,
   input  logic [rvPkg::RegIdxW-1:0] wAddr,
   input  logic [rvPkg::Xlen-1:0]    wData,
   output logic [rvPkg::Xlen-1:0]    rs1Data,
   output logic [rvPkg::Xlen-1:0]    rs2Data
);

   localparam int NumRegs = 2 ** rvPkg::RegIdxW;

   logic [rvPkg::Xlen-1:0] regs [NumRegs];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn && (wAddr != '0)) begin  // x0 stays zero
         regs[wAddr] <= wData;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

endmodule

// File: hdl/rvSeqCtrl.sv
module rvSeqCtrl #(
   parameter int unsigned AddrW   = 32,
   parameter int unsigned PcStart = 0
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      memVld,
   input  logic [rvPkg::Xlen-1:0]    memRData,
   input  logic                      loadEn,
   input  logic                      isAlu,
   input  logic                      isLui,
   input  logic                      isLoad,
   input  logic                      isStore,
   input  logic                      isHalt,
   input  logic                      isInvalid,
   input  logic [rvPkg::Xlen-1:0]    imm,
   input  logic [rvPkg::RegIdxW-1:0] rd,
   input  logic [rvPkg::Xlen-1:0]    aluResult,
   input  logic [rvPkg::Xlen-1:0]    rs2Data,
   output logic [rvPkg::Xlen-1:0]    instr,
   output logic                      memRdy,
   output logic [AddrW-1:0]          memAddr,
   output logic                      memWEn,
   output logic [rvPkg::Xlen-1:0]    memWData,
   output logic                      halt,
   output logic                      regWEn,
   output logic [rvPkg::RegIdxW-1:0] regWAddr,
   output logic [rvPkg::Xlen-1:0]    regWData
);

   typedef enum logic [1:0] {
      stHalted,
      stFetch,
      stExec,
      stMem
   } stateE;

   stateE            state;
   logic [AddrW-1:0] pc;
   logic             memDone;
   logic             isMemOp;

   assign memDone = memRdy && memVld;  // memVld alone is ignored
   assign isMemOp = isLoad || isStore;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= stHalted;
         halt   <= 1'b1;
         memRdy <= 1'b0;
         memWEn <= 1'b0;
         pc     <= AddrW'(PcStart);
      end else begin
         case (state)
            stHalted: begin
               if (loadEn) begin
                  halt   <= 1'b0;
                  memRdy <= 1'b1;
                  state  <= stFetch;
               end
            end
            stFetch: begin
               if (!memRdy) begin
                  memRdy <= 1'b1;     // first cycle after a data access
               end else if (memVld) begin
                  memRdy <= 1'b0;
                  pc     <= pc + AddrW'(1);
                  state  <= stExec;
               end
            end
            stExec: begin
               if (isHalt || isInvalid) begin
                  halt  <= 1'b1;
                  state <= stHalted;
               end else if (isMemOp) begin
                  memRdy <= 1'b1;
                  memWEn <= isStore;
                  state  <= stMem;
               end else begin
                  memRdy <= 1'b1;     // alu or lui, straight to next fetch
                  state  <= stFetch;
               end
            end
            stMem: begin
               if (memDone) begin
                  memRdy <= 1'b0;
                  memWEn <= 1'b0;
                  state  <= stFetch;
               end
            end
            default: state <= stHalted;
         endcase
      end
   end

   // request payload, held while memRdy is up
   always_ff @(posedge clk) begin
      case (state)
         stHalted: begin
            memAddr <= pc;
         end
         stFetch: begin
            if (!memRdy) begin
               memAddr <= pc;
            end else if (memVld) begin
               instr <= memRData;
            end
         end
         stExec: begin
            if (isMemOp) begin
               memAddr  <= AddrW'(aluResult);
               memWData <= rs2Data;
            end else begin
               memAddr <= pc;         // pc already points past this one
            end
         end
         default: ;
      endcase
   end

   // write-back
   always_comb begin
      regWAddr = rd;
      regWEn   = 1'b0;
      regWData = isLui ? imm : aluResult;
      if (state == stExec) begin
         regWEn = isAlu || isLui;
      end else if (state == stMem) begin
         regWEn   = isLoad && memDone;
         regWData = memRData;
      end
   end

endmodule

// File: list.f
hdl/rvPkg.sv
hdl/rvDecoder.sv
hdl/rvAlu.sv
hdl/rvRegFile.sv
hdl/rvSeqCtrl.sv
hdl/rvCore.sv
test/rvCore_checker.sv
test/rvCoreTb.sv

// File: test/rvCoreTb.sv
module rvCoreTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned AddrW     = 32;
   localparam int unsigned PcStart   = 16;
   localparam int          MemW      = 13;
   localparam int          MemWords  = 2 ** MemW;
   localparam int          WaitLimit = 5000;
   localparam int          StoreBase = 1024;  // stores land above the program
   localparam logic [31:0] HaltWord  = {25'b0, rvPkg::opHalt};
   localparam logic [2:0]  RegF3 [6] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd1};
   localparam logic [2:0]  ImmF3 [7] = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};

   logic                   clk = 1'b0;
   logic                   rstn;
   logic                   memVld;
   logic [rvPkg::Xlen-1:0] memRData;
   logic                   loadEn;
   logic                   memRdy;
   logic [AddrW-1:0]       memAddr;
   logic                   memWEn;
   logic [rvPkg::Xlen-1:0] memWData;
   logic                   halt;

   logic [31:0] mem [MemWords];
   logic [31:0] refMem [MemWords];
   logic [31:0] refRegs [32];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic [31:0] resumePc [$];
   int          seed;
   int          errCount = 0;
   int          checkCount = 0;
   int          testCount = 0;
   int          genPc;
   int          storeIdx;
   int          latency;
   bit          inReq;

   rvCore #(
      .AddrW   (AddrW),
      .PcStart (PcStart)
   ) i_rvCore (
      .clk      (clk),
      .rstn     (rstn),
      .memVld   (memVld),
      .memRData (memRData),
      .loadEn   (loadEn),
      .memRdy   (memRdy),
      .memAddr  (memAddr),
      .memWEn   (memWEn),
      .memWData (memWData),
      .halt     (halt)
   );

   always #10 clk = ~clk;

   function automatic int unsigned urand(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rvPkg::opReg};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
      return {imm[11:5], rs2, 5'd0, rvPkg::Funct3Lw, imm[4:0], rvPkg::opStore};  // base x0
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, rvPkg::opLui};
   endfunction

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERROR %s: got %08h, expected %08h", name, got, exp);
      end
   endtask

   task automatic finishRun();
      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   task automatic waitFor(input bit useHalt, input string what);
      int n;
      for (n = 0; n < WaitLimit; n++) begin
         @(negedge clk);
         if (useHalt ? halt : memRdy) break;
      end
      if (n == WaitLimit) begin
         errCount++;
         $display("timeout: %s did not rise within %0d cycles", what, WaitLimit);
         finishRun();
      end
   endtask

   // memory model, answers after 0 to 4 cycles
   always @(posedge clk) begin
      if (!rstn) begin
         memVld <= 1'b0;
         inReq = 1'b0;
      end else if (memVld) begin  // request completes at this edge
         memVld <= 1'b0;
         inReq = 1'b0;
         if (memWEn) begin
            mem[memAddr[MemW-1:0]] = memWData;
            if (expAddr.size() == 0) begin
               errCount++;
               $display("store to %08h happened where the model expects none", memAddr);
            end else begin
               checkEq("memAddr", memAddr, expAddr.pop_front());
               checkEq("memWData", memWData, expData.pop_front());
            end
         end
      end else if (memRdy) begin
         if (!inReq) begin
            inReq = 1'b1;
            latency = urand(5);
         end
         if (latency == 0) begin
            memVld   <= 1'b1;
            memRData <= mem[memAddr[MemW-1:0]];
         end else begin
            latency--;
         end
      end
   end

   task automatic emit(input logic [31:0] word);
      mem[genPc] = word;
      genPc++;
   endtask

   task automatic emitStore(input logic [4:0] rs);
      emit(encS(12'(StoreBase + storeIdx), rs));
      storeIdx++;
   endtask

   task automatic seedRegs();
      for (int r = 1; r < 8; r++) begin
         emit(encU(20'(urand(1 << 20)), 5'(r)));
         emit(encI(12'(urand(4096)), 5'(r), 3'd0, 5'(r), rvPkg::opImm));
      end
   endtask

   task automatic emitAlu(input logic [4:0] rd);
      int unsigned sel;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      sel = urand(13);
      rs1 = 5'(urand(8));
      rs2 = 5'(urand(8));
      imm = 12'(urand(4096));
      if (sel < 6) begin
         emit(encR((sel == 1) ? rvPkg::Funct7Alt : 7'b0, rs2, rs1, RegF3[sel], rd));
      end else begin
         if (sel >= 10) begin  // shift amount with funct7 on top
            imm = {(sel == 12) ? rvPkg::Funct7Alt : 7'b0, imm[4:0]};
         end
         emit(encI(imm, rs1, ImmF3[sel-6], rd, rvPkg::opImm));
      end
   endtask

   task automatic emitLoad(input logic [4:0] rd);
      emit(encI(12'(urand(64)), 5'd5, rvPkg::Funct3Lw, rd, rvPkg::opLoad));
   endtask

   task automatic buildProgram(input int kind, output int halts);
      logic [4:0] rd;
      halts = 1;
      seedRegs();
      case (kind)
         0: emitStore(5'd1);
         1: begin
            repeat (24) begin
               rd = 5'(urand(8));
               emitAlu(rd);
               emitStore(rd);
            end
         end
         2: begin
            emit(encU(20'h1, 5'd5));  // x5 = 4096, data words
            repeat (12) begin
               rd = 5'(urand(8));
               rd = (rd == 5'd5) ? 5'd0 : rd;
               emitLoad(rd);
               emitStore(rd);
            end
            emit(encU(20'(urand(1 << 20)), 5'd6));
            emitStore(5'd6);
         end
         3: begin
            emit(HaltWord);
            emitAlu(5'd3);
            emitStore(5'd3);
            emit(HaltWord);
            emitStore(5'd1);
            halts = 3;
         end
         4: begin
            emit(encR(7'b0000001, 5'd1, 5'd2, 3'd0, 5'd2));  // bad funct7
            emitStore(5'd2);
            emit(encI(12'd1024, 5'd0, 3'd0, 5'd3, rvPkg::opLoad));  // lb
            emitStore(5'd3);
            emit(encI(12'(urand(4096)), 5'd1, 3'd0, 5'd4, 7'h0F));
            emitStore(5'd4);
            halts = 4;
         end
         default: begin
            emit(encU(20'h1, 5'd5));
            repeat (40) begin
               rd = 5'(urand(8));
               rd = (rd == 5'd5) ? 5'd0 : rd;
               if (urand(3) == 0) begin
                  emitLoad(rd);
               end else begin
                  emitAlu(rd);
               end
               emitStore(rd);
            end
         end
      endcase
      emit(HaltWord);
   endtask

   // instruction-set model over refMem and refRegs
   task automatic modelRun(input int numHalts);
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] immI;
      logic [31:0] addr;
      logic [31:0] res;
      logic [31:0] pc;
      int          halts;
      int          steps;
      bit          bad;
      bit          wr;
      pc = PcStart;
      halts = 0;
      steps = 0;
      resumePc.push_back(PcStart);
      for (int r = 0; r < 32; r++) begin
         refRegs[r] = '0;
      end
      while (halts < numHalts && steps < 4096) begin
         ins  = refMem[pc[MemW-1:0]];
         pc   = pc + 1;
         a    = refRegs[ins[19:15]];
         b    = refRegs[ins[24:20]];
         immI = {{20{ins[31]}}, ins[31:20]};
         bad  = 1'b0;
         wr   = 1'b1;
         res  = '0;
         case (ins[6:0])
            rvPkg::opReg: begin
               case ({ins[31:25], ins[14:12]})
                  10'h000: res = a + b;
                  10'h100: res = a - b;
                  10'h004: res = a ^ b;
                  10'h006: res = a | b;
                  10'h007: res = a & b;
                  10'h001: res = a << b[4:0];
                  default: bad = 1'b1;
               endcase
            end
            rvPkg::opImm: begin
               case (ins[14:12])
                  3'd0: res = a + immI;
                  3'd4: res = a ^ immI;
                  3'd6: res = a | immI;
                  3'd7: res = a & immI;
                  3'd1: begin
                     res = a << ins[24:20];
                     bad = (ins[31:25] != 7'b0);
                  end
                  3'd5: begin
                     if (ins[30]) begin
                        res = $signed(a) >>> ins[24:20];
                     end else begin
                        res = a >> ins[24:20];
                     end
                     bad = ((ins[31:25] & 7'h5F) != 7'b0);  // only bit 30 may be set
                  end
                  default: bad = 1'b1;
               endcase
            end
            rvPkg::opLui: res = {ins[31:12], 12'h0};
            rvPkg::opLoad: begin
               addr = a + immI;
               res  = refMem[addr[MemW-1:0]];
               bad  = (ins[14:12] != rvPkg::Funct3Lw);
            end
            rvPkg::opStore: begin
               wr = 1'b0;
               bad = (ins[14:12] != rvPkg::Funct3Lw);
               if (!bad) begin
                  addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                  refMem[addr[MemW-1:0]] = b;
                  expAddr.push_back(addr);
                  expData.push_back(b);
               end
            end
            default: bad = 1'b1;  // halt opcode too
         endcase
         if (bad) begin
            halts++;
            if (halts < numHalts) begin
               resumePc.push_back(pc);
            end
         end else if (wr && ins[11:7] != 5'd0) begin
            refRegs[ins[11:7]] = res;
         end
         steps++;
      end
   endtask

   task automatic runTest(input int kind, input string name);
      int errStart;
      int chkStart;
      int halts;
      errStart = errCount;
      chkStart = checkCount;
      @(posedge clk);
      rstn <= 1'b0;
      for (int i = 0; i < MemWords; i++) begin
         mem[i] = $random(seed);
      end
      expAddr.delete();
      expData.delete();
      resumePc.delete();
      storeIdx = 0;
      genPc = PcStart;
      buildProgram(kind, halts);
      refMem = mem;
      modelRun(halts);
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         checkEq("halt", halt, 1'b1);
         checkEq("memRdy", memRdy, 1'b0);
         checkEq("memWEn", memWEn, 1'b0);
      end
      for (int h = 0; h < halts; h++) begin
         @(posedge clk);
         loadEn <= 1'b1;
         @(posedge clk);
         loadEn <= 1'b0;
         waitFor(1'b0, "memRdy");
         checkEq("memAddr", memAddr, resumePc.pop_front());  // first fetch after release
         waitFor(1'b1, "halt");
         checkEq("memRdy", memRdy, 1'b0);
      end
      checkEq("pending stores", expAddr.size(), 0);
      for (int i = 0; i < MemWords; i++) begin
         checkEq("mem", mem[i], refMem[i]);
      end
      testCount++;
      $display("test %0d %s: %0d checks, %0d errors", kind, name,
               checkCount - chkStart, errCount - errStart);
   endtask

   initial begin
      seed     = 32'h3237_f2c0;
      rstn     = 1'b0;
      loadEn   = 1'b0;
      memVld   = 1'b0;
      memRData = '0;
      runTest(0, "reset and start");
      runTest(1, "alu and immediate ops");
      runTest(2, "lui and loads");
      runTest(3, "halt and resume");
      runTest(4, "invalid instructions");
      runTest(5, "random stalls");
      finishRun();
   end

endmodule

// File: test/rvCore_checker.sv
module rvCoreChecker #(
   parameter int unsigned AddrW = 32
) (
   input logic                   clk,
   input logic                   rstn,
   input logic                   memRdy,
   input logic                   memVld,
   input logic [AddrW-1:0]       memAddr,
   input logic                   memWEn,
   input logic [rvPkg::Xlen-1:0] memWData,
   input logic                   halt
);
   timeunit 1ns;
   timeprecision 1ps;

   writeInRequest: assert property (@(posedge clk) disable iff (!rstn) memWEn |-> memRdy)
      else $error("memWEn high without memRdy");

   haltIdle: assert property (@(posedge clk) disable iff (!rstn) !(memRdy && halt))
      else $error("memRdy and halt high together");

   // request payload held until memVld
   reqStable: assert property (@(posedge clk) disable iff (!rstn)
      memRdy && !memVld |=> $stable(memAddr) && $stable(memWEn))
      else $error("memAddr or memWEn changed during a request");

   wDataStable: assert property (@(posedge clk) disable iff (!rstn)
      memRdy && memWEn && !memVld |=> $stable(memWData))
      else $error("memWData changed during a store");

   reqDrops: assert property (@(posedge clk) disable iff (!rstn) memRdy && memVld |=> !memRdy)
      else $error("memRdy still high after memVld");

endmodule

bind rvCore rvCoreChecker #(.AddrW(AddrW)) i_rvCoreChecker (.*);
